// File: verilog/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// datapath and register file shape.
`define CORE_XLEN 32
`define CORE_NREGS 32

// data RAM size in 32-bit words.
`define CORE_DMEM_WORDS 256

// retiring this pc raises exit.
`define CORE_EXIT_PC 32'h00000044

// reset values for x2 and for the remaining nonzero registers.
`define CORE_SP_RESET 32'h00002000
`define CORE_REG_RESET 32'hffffffff

// id held before the first retirement.
`define CORE_INST_ID_NOP 64'hffff_ffff_ffff_ffff

`endif

// File: verilog/core_pkg.sv
`default_nettype none

`include "core_macros.svh"

package core_pkg;

    localparam int REG_AW = $clog2(`CORE_NREGS);

    // mem_size encodings.
    localparam logic [1:0] MEM_SIZE_B = 2'b00;
    localparam logic [1:0] MEM_SIZE_H = 2'b01;
    localparam logic [1:0] MEM_SIZE_W = 2'b10;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU, COPY_B
    } alu_op_e;

    typedef enum logic [2:0] {
        WB_ALU, WB_MEMB, WB_MEMBU, WB_MEMH, WB_MEMHU, WB_MEMW, WB_PC
    } wb_sel_e;

    typedef enum logic {
        OPB_RS2, OPB_IMM
    } op_b_src_e;

    typedef enum logic [1:0] {
        FWD_RF, FWD_MEM, FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e     alu_op;
        op_b_src_e   op_b_src;
        wb_sel_e     wb_sel;
        logic        rf_wen;
        logic        mem_wen;
        logic [1:0]  mem_size;
        logic [REG_AW-1:0] wb_addr;
    } ctrl_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        logic [63:0]           inst_id;
        logic [REG_AW-1:0]     rs1;
        logic [REG_AW-1:0]     rs2;
        logic [`CORE_XLEN-1:0] imm;
        ctrl_t                 ctrl;
    } issue_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        logic [63:0]           inst_id;
        ctrl_t                 ctrl;
        logic [`CORE_XLEN-1:0] alu_out;
        logic [`CORE_XLEN-1:0] store_data;
    } ex_mem_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        logic [63:0]           inst_id;
        ctrl_t                 ctrl;
        logic [`CORE_XLEN-1:0] alu_out;
        logic [`CORE_XLEN-1:0] mem_rdata; // shifted down, not extended.
    } mem_wb_t;

    typedef struct packed {
        logic                  wen;
        logic [REG_AW-1:0]     addr;
        logic [`CORE_XLEN-1:0] data;
    } rf_wr_t;

endpackage

`default_nettype wire

// File: verilog/regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module regfile import core_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n_i,
    input  wire [REG_AW-1:0]      rs1_i,
    input  wire [REG_AW-1:0]      rs2_i,
    output logic [`CORE_XLEN-1:0] rs1_data_o,
    output logic [`CORE_XLEN-1:0] rs2_data_o,
    input  wire [REG_AW-1:0]      dbg_addr_i,
    output logic [`CORE_XLEN-1:0] dbg_data_o,
    input  rf_wr_t                wr_i
);

    logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                if (i == 0)
                    regs[i] <= '0;
                else if (i == 2)
                    regs[i] <= `CORE_SP_RESET; // stack pointer.
                else
                    regs[i] <= `CORE_REG_RESET;
            end
        end else if (wr_i.wen && wr_i.addr != '0) begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    // forwarding from the write-back stage stands in for a write bypass.
    always_comb begin
        rs1_data_o = regs[rs1_i];
        rs2_data_o = regs[rs2_i];
        dbg_data_o = regs[dbg_addr_i];
    end

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module execute_stage import core_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n_i,
    input  wire                   take_i,
    input  issue_t                issue_i,
    input  wire [`CORE_XLEN-1:0]  rs1_data_i,
    input  wire [`CORE_XLEN-1:0]  rs2_data_i,
    input  fwd_sel_e              fwd_a_i,
    input  fwd_sel_e              fwd_b_i,
    input  wire [`CORE_XLEN-1:0]  mem_fwd_i,
    input  wire [`CORE_XLEN-1:0]  wb_fwd_i,
    output ex_mem_t               ex_q_o,
    output logic                  ex_valid_o
);

    logic [`CORE_XLEN-1:0] rs1_val;
    logic [`CORE_XLEN-1:0] rs2_val;
    logic [`CORE_XLEN-1:0] op_b;
    logic [`CORE_XLEN-1:0] alu_out;
    logic [4:0]            shamt;

    always_comb begin
        case (fwd_a_i)
            FWD_MEM: rs1_val = mem_fwd_i;
            FWD_WB:  rs1_val = wb_fwd_i;
            default: rs1_val = rs1_data_i;
        endcase
        case (fwd_b_i)
            FWD_MEM: rs2_val = mem_fwd_i;
            FWD_WB:  rs2_val = wb_fwd_i;
            default: rs2_val = rs2_data_i;
        endcase
        op_b = (issue_i.ctrl.op_b_src == OPB_IMM) ? issue_i.imm : rs2_val;
        shamt = op_b[4:0];
    end

    always_comb begin
        case (issue_i.ctrl.alu_op)
            ADD:    alu_out = rs1_val + op_b;
            SUB:    alu_out = rs1_val - op_b;
            AND:    alu_out = rs1_val & op_b;
            OR:     alu_out = rs1_val | op_b;
            XOR:    alu_out = rs1_val ^ op_b;
            SLL:    alu_out = rs1_val << shamt;
            SRL:    alu_out = rs1_val >> shamt;
            SRA:    alu_out = $signed(rs1_val) >>> shamt;
            SLT:    alu_out = {{(`CORE_XLEN-1){1'b0}}, $signed(rs1_val) < $signed(op_b)};
            SLTU:   alu_out = {{(`CORE_XLEN-1){1'b0}}, rs1_val < op_b};
            default: alu_out = op_b; // COPY_B, e.g. lui.
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i)
            ex_valid_o <= 1'b0;
        else
            ex_valid_o <= take_i; // bubble while stalled.
    end

    always_ff @(posedge clk) begin
        if (take_i) begin
            ex_q_o.pc         <= issue_i.pc;
            ex_q_o.inst_id    <= issue_i.inst_id;
            ex_q_o.ctrl       <= issue_i.ctrl;
            ex_q_o.alu_out    <= alu_out;
            ex_q_o.store_data <= rs2_val;
        end
    end

endmodule

`default_nettype wire

// File: verilog/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module memory_stage import core_pkg::*; (
    input  wire     clk,
    input  wire     rst_n_i,
    input  ex_mem_t ex_q_i,
    input  wire     ex_valid_i,
    output mem_wb_t wb_q_o,
    output logic    wb_valid_o
);

    localparam int DMEM_AW = $clog2(`CORE_DMEM_WORDS);

    logic [`CORE_XLEN-1:0] dmem [`CORE_DMEM_WORDS];

    logic [DMEM_AW-1:0]    word_idx;
    logic [1:0]            byte_off;
    logic [3:0]            byte_en;
    logic [`CORE_XLEN-1:0] wdata;
    logic [`CORE_XLEN-1:0] rdata_word;
    logic [`CORE_XLEN-1:0] rdata_shift;

    assign word_idx = ex_q_i.alu_out[DMEM_AW+1:2];
    assign byte_off = ex_q_i.alu_out[1:0];

    // replicate the store data so every lane carries the right bytes.
    always_comb begin
        case (ex_q_i.ctrl.mem_size)
            MEM_SIZE_B: begin
                byte_en = 4'b0001 << byte_off;
                wdata   = {4{ex_q_i.store_data[7:0]}};
            end
            MEM_SIZE_H: begin
                byte_en = 4'b0011 << byte_off;
                wdata   = {2{ex_q_i.store_data[15:0]}};
            end
            MEM_SIZE_W: begin
                byte_en = 4'b1111;
                wdata   = ex_q_i.store_data;
            end
            default: begin
                byte_en = 4'b0000; // reserved size.
                wdata   = ex_q_i.store_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (ex_valid_i && ex_q_i.ctrl.mem_wen) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b])
                    dmem[word_idx][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

    assign rdata_word  = dmem[word_idx];
    assign rdata_shift = rdata_word >> {byte_off, 3'b000}; // addressed lane to bit 0.

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i)
            wb_valid_o <= 1'b0;
        else
            wb_valid_o <= ex_valid_i;
    end

    always_ff @(posedge clk) begin
        wb_q_o.pc        <= ex_q_i.pc;
        wb_q_o.inst_id   <= ex_q_i.inst_id;
        wb_q_o.ctrl      <= ex_q_i.ctrl;
        wb_q_o.alu_out   <= ex_q_i.alu_out;
        wb_q_o.mem_rdata <= rdata_shift;
    end

endmodule

`default_nettype wire

// File: verilog/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module writeback_stage import core_pkg::*; (
    input  mem_wb_t               wb_q_i,
    input  wire                   wb_valid_i,
    output logic [`CORE_XLEN-1:0] wb_data_o,
    output rf_wr_t                rf_wr_o
);

    logic [`CORE_XLEN-1:0] rdata;
    logic [`CORE_XLEN-1:0] link_pc;

    assign rdata   = wb_q_i.mem_rdata;
    assign link_pc = wb_q_i.pc + `CORE_XLEN'd4;

    always_comb begin
        case (wb_q_i.ctrl.wb_sel)
            WB_MEMB: begin
                wb_data_o = {{(`CORE_XLEN-8){rdata[7]}}, rdata[7:0]};
            end
            WB_MEMBU: begin
                wb_data_o = {{(`CORE_XLEN-8){1'b0}}, rdata[7:0]};
            end
            WB_MEMH: begin
                wb_data_o = {{(`CORE_XLEN-16){rdata[15]}}, rdata[15:0]};
            end
            WB_MEMHU: begin
                wb_data_o = {{(`CORE_XLEN-16){1'b0}}, rdata[15:0]};
            end
            WB_MEMW: begin
                wb_data_o = rdata;
            end
            WB_PC: begin
                wb_data_o = link_pc; // jal / jalr return address.
            end
            default: begin
                wb_data_o = wb_q_i.alu_out;
            end
        endcase
    end

    // x0 writes are dropped here as well as in the register file.
    always_comb begin
        rf_wr_o.wen  = wb_valid_i && wb_q_i.ctrl.rf_wen && (wb_q_i.ctrl.wb_addr != '0);
        rf_wr_o.addr = wb_q_i.ctrl.wb_addr;
        rf_wr_o.data = wb_data_o;
    end

endmodule

`default_nettype wire

// File: verilog/pipe_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module pipe_control import core_pkg::*; (
    input  wire         clk,
    input  wire         rst_n_i,
    input  wire         issue_valid_i,
    input  issue_t      issue_i,
    input  ex_mem_t     ex_q_i,
    input  wire         ex_valid_i,
    input  mem_wb_t     wb_q_i,
    input  wire         wb_valid_i,
    output fwd_sel_e    fwd_a_o,
    output fwd_sel_e    fwd_b_o,
    output logic        stall_o,
    output logic        take_o,
    output logic [31:0] retire_count_o,
    output logic        exit_o
);

    logic        mem_writes;
    logic        wb_writes;
    logic        mem_is_load;
    logic        src_hit;
    logic        new_retire;
    logic [63:0] last_id;

    // producers that actually write a nonzero register.
    assign mem_writes = ex_valid_i && ex_q_i.ctrl.rf_wen && (ex_q_i.ctrl.wb_addr != '0);
    assign wb_writes  = wb_valid_i && wb_q_i.ctrl.rf_wen && (wb_q_i.ctrl.wb_addr != '0);

    function automatic fwd_sel_e fwd_pick(input logic [REG_AW-1:0] rs);
        if (mem_writes && ex_q_i.ctrl.wb_addr == rs)
            return FWD_MEM; // youngest producer wins.
        else if (wb_writes && wb_q_i.ctrl.wb_addr == rs)
            return FWD_WB;
        else
            return FWD_RF;
    endfunction

    always_comb begin
        fwd_a_o = fwd_pick(issue_i.rs1);
        fwd_b_o = fwd_pick(issue_i.rs2);
    end

    // only the ALU result is forwarded from the memory stage, so loads there stall.
    always_comb begin
        case (ex_q_i.ctrl.wb_sel)
            WB_MEMB, WB_MEMBU, WB_MEMH, WB_MEMHU, WB_MEMW: mem_is_load = 1'b1;
            default: mem_is_load = 1'b0;
        endcase
    end

    assign src_hit = (ex_q_i.ctrl.wb_addr == issue_i.rs1) ||
                     (ex_q_i.ctrl.wb_addr == issue_i.rs2);
    assign stall_o = issue_valid_i && mem_writes && mem_is_load && src_hit;
    assign take_o  = issue_valid_i && !stall_o;

    assign new_retire = wb_valid_i && (wb_q_i.inst_id != last_id);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            retire_count_o <= '0;
            last_id        <= `CORE_INST_ID_NOP;
            exit_o         <= 1'b0;
        end else if (new_retire) begin
            retire_count_o <= retire_count_o + 32'd1;
            last_id        <= wb_q_i.inst_id;
            if (wb_q_i.pc == `CORE_EXIT_PC)
                exit_o <= 1'b1; // sticky.
        end
    end

endmodule

`default_nettype wire

// File: verilog/backend_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module backend_top import core_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n_i,
    input  wire                   issue_valid_i,
    input  issue_t                issue_i,
    input  wire [REG_AW-1:0]      dbg_addr_i,
    output logic                  stall_o,
    output logic [`CORE_XLEN-1:0] dbg_data_o,
    output logic [31:0]           retire_count_o,
    output logic                  exit_o
);

    logic                  take;
    fwd_sel_e              fwd_a;
    fwd_sel_e              fwd_b;
    logic [`CORE_XLEN-1:0] rs1_data;
    logic [`CORE_XLEN-1:0] rs2_data;
    ex_mem_t               ex_q;
    logic                  ex_valid;
    mem_wb_t               wb_q;
    logic                  wb_valid;
    logic [`CORE_XLEN-1:0] wb_data;
    rf_wr_t                rf_wr;

    pipe_control u_ctrl (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .issue_valid_i  (issue_valid_i),
        .issue_i        (issue_i),
        .ex_q_i         (ex_q),
        .ex_valid_i     (ex_valid),
        .wb_q_i         (wb_q),
        .wb_valid_i     (wb_valid),
        .fwd_a_o        (fwd_a),
        .fwd_b_o        (fwd_b),
        .stall_o        (stall_o),
        .take_o         (take),
        .retire_count_o (retire_count_o),
        .exit_o         (exit_o)
    );

    regfile u_rf (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_i      (issue_i.rs1),
        .rs2_i      (issue_i.rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .dbg_addr_i (dbg_addr_i),
        .dbg_data_o (dbg_data_o),
        .wr_i       (rf_wr)
    );

    execute_stage u_ex (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .take_i     (take),
        .issue_i    (issue_i),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .fwd_a_i    (fwd_a),
        .fwd_b_i    (fwd_b),
        .mem_fwd_i  (ex_q.alu_out), // memory-stage ALU result.
        .wb_fwd_i   (wb_data),
        .ex_q_o     (ex_q),
        .ex_valid_o (ex_valid)
    );

    memory_stage u_mem (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .ex_q_i     (ex_q),
        .ex_valid_i (ex_valid),
        .wb_q_o     (wb_q),
        .wb_valid_o (wb_valid)
    );

    writeback_stage u_wb (
        .wb_q_i     (wb_q),
        .wb_valid_i (wb_valid),
        .wb_data_o  (wb_data),
        .rf_wr_o    (rf_wr)
    );

endmodule

`default_nettype wire

// File: verif/backend_tests.svh
    function automatic issue_t make_ins(input alu_op_e op, input op_b_src_e bsrc,
                                        input wb_sel_e sel, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [4:0] rs2,
                                        input logic [31:0] imm);
        issue_t ins;
        ins = '0;
        ins.rs1 = rs1;
        ins.rs2 = rs2;
        ins.imm = imm;
        ins.ctrl.alu_op = op;
        ins.ctrl.op_b_src = bsrc;
        ins.ctrl.wb_sel = sel;
        ins.ctrl.rf_wen = 1'b1;
        ins.ctrl.wb_addr = rd;
        return ins;
    endfunction

    function automatic issue_t store_ins(input logic [1:0] size, input logic [4:0] base,
                                         input logic [4:0] src, input logic [31:0] off);
        issue_t ins;
        ins = make_ins(ADD, OPB_IMM, WB_ALU, 5'd0, base, src, off);
        ins.ctrl.rf_wen = 1'b0;
        ins.ctrl.mem_wen = 1'b1;
        ins.ctrl.mem_size = size;
        return ins;
    endfunction

    function automatic logic [31:0] load_model(input wb_sel_e sel, input logic [31:0] word,
                                               input int off);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = (off == 2) ? word[31:16] : word[15:0];
        case (sel)
            WB_MEMB:  return {{24{b[7]}}, b};
            WB_MEMBU: return {24'd0, b};
            WB_MEMH:  return {{16{h[15]}}, h};
            WB_MEMHU: return {16'd0, h};
            default:  return word;
        endcase
    endfunction

    // holds the instruction while stall_o is high, returns at the taking edge.
    task automatic send(input issue_t ins);
        @(negedge clk);
        issue_valid_i = 1'b1;
        issue_i = ins;
        last_stalls = 0;
        #(CLK_HALF / 2);
        while (stall_o) begin
            last_stalls++;
            if (last_stalls > MAX_STALLS) begin
                $display("stall_o held the issue for too many cycles");
                $display("Some tests failed");
                $fatal(1, "stall timeout");
            end
            @(negedge clk);
            #(CLK_HALF / 2);
        end
        @(posedge clk);
    endtask

    task automatic issue(input issue_t ins);
        issue_t stamped;
        stamped = ins;
        stamped.pc = pc_next;
        stamped.inst_id = id_next;
        pc_next = pc_next + 32'd4;
        id_next = id_next + 64'd1;
        exp_retired = exp_retired + 32'd1;
        send(stamped);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            issue_valid_i = 1'b0;
        end
    endtask

    task automatic expect_reg(input int r, input logic [31:0] exp);
        @(negedge clk);
        issue_valid_i = 1'b0;
        dbg_addr_i = r[4:0];
        #(CLK_HALF / 2);
        check_val($sformatf("dbg_data_o[x%0d]", r), dbg_data_o, exp);
    endtask

    task automatic expect_all();
        for (int r = 0; r < `CORE_NREGS; r++)
            expect_reg(r, model_rf[r[4:0]]);
    endtask

    task automatic reset_values();
        expect_all();
        check_val("retire_count_o", retire_count_o, 32'd0);
        check_val("exit_o", 32'(exit_o), 32'd0);
    endtask

    task automatic alu_forwarding();
        logic [31:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs2;
        logic [4:0]  prev;
        alu_op_e     op;
        int          k;
        for (int i = 1; i < 8; i++) begin
            imm = $random(seed);
            issue(make_ins(COPY_B, OPB_IMM, WB_ALU, i[4:0], 5'd0, 5'd0, imm));
            model_rf[i[4:0]] = imm;
        end
        issue(make_ins(COPY_B, OPB_IMM, WB_ALU, 5'd0, 5'd0, 5'd0, 32'hdeadbeef)); // dropped.
        prev = 5'd7;
        for (int i = 0; i < 24; i++) begin
            k = $unsigned($random(seed)) % 10;
            op = alu_op_e'(k[3:0]);
            k = $unsigned($random(seed)) % 8;
            rd = k[4:0];
            k = $unsigned($random(seed)) % 8;
            rs2 = k[4:0];
            issue(make_ins(op, OPB_RS2, WB_ALU, rd, prev, rs2, 32'd0));
            if (rd != 5'd0)
                model_rf[rd] = alu_model(op, model_rf[prev], model_rf[rs2]);
            prev = rd; // next instruction depends on this one.
        end
        idle(3);
        expect_all();
    endtask

    task automatic load_check(input wb_sel_e sel, input int off);
        issue(make_ins(ADD, OPB_IMM, sel, 5'd12, 5'd10, 5'd0, 32'(off)));
        model_rf[12] = load_model(sel, mem_word, off);
        idle(3);
        expect_reg(12, model_rf[12]);
    endtask

    task automatic load_extension();
        mem_word = ($random(seed) & 32'h7f7f7f7f) | 32'h80800000;
        issue(make_ins(COPY_B, OPB_IMM, WB_ALU, 5'd10, 5'd0, 5'd0, 32'h100));
        issue(make_ins(COPY_B, OPB_IMM, WB_ALU, 5'd11, 5'd0, 5'd0, mem_word));
        issue(store_ins(MEM_SIZE_W, 5'd10, 5'd11, 32'd0));
        issue(store_ins(MEM_SIZE_B, 5'd10, 5'd11, 32'd1)); // only lane 1 changes.
        model_rf[10] = 32'h100;
        model_rf[11] = mem_word;
        mem_word[15:8] = mem_word[7:0];
        for (int off = 0; off < 4; off++) begin
            load_check(WB_MEMB, off);
            load_check(WB_MEMBU, off);
        end
        for (int off = 0; off < 4; off += 2) begin
            load_check(WB_MEMH, off);
            load_check(WB_MEMHU, off);
        end
        load_check(WB_MEMW, 0);
    endtask

    task automatic load_use_stall();
        issue(make_ins(ADD, OPB_IMM, WB_MEMW, 5'd20, 5'd10, 5'd0, 32'd0));
        check_val("stall cycles of load", last_stalls, 32'd0);
        issue(make_ins(ADD, OPB_IMM, WB_ALU, 5'd21, 5'd20, 5'd0, 32'd1));
        check_val("stall cycles of use", last_stalls, 32'd1);
        model_rf[20] = mem_word;
        model_rf[21] = mem_word + 32'd1;
        idle(3);
        expect_reg(20, model_rf[20]);
        expect_reg(21, model_rf[21]);
    endtask

    task automatic link_and_retire();
        issue_t ins;
        model_rf[1] = pc_next + 32'd4;
        issue(make_ins(ADD, OPB_IMM, WB_PC, 5'd1, 5'd0, 5'd0, 32'd0));
        idle(3);
        expect_reg(1, model_rf[1]);
        check_val("retire_count_o", retire_count_o, exp_retired);
        ins = make_ins(ADD, OPB_IMM, WB_ALU, 5'd5, 5'd0, 5'd0, 32'h33);
        ins.pc = 32'h200;
        ins.inst_id = id_next;
        id_next = id_next + 64'd1;
        send(ins);
        send(ins); // same id retires once.
        idle(3);
        exp_retired = exp_retired + 32'd1;
        check_val("retire_count_o", retire_count_o, exp_retired);
        issue(make_ins(ADD, OPB_IMM, WB_ALU, 5'd6, 5'd0, 5'd0, 32'h44));
        idle(3);
        check_val("retire_count_o", retire_count_o, exp_retired);
    endtask

    task automatic exit_flag();
        issue_t ins;
        ins = make_ins(COPY_B, OPB_IMM, WB_ALU, 5'd3, 5'd0, 5'd0, 32'h5a5a);
        ins.pc = `CORE_EXIT_PC;
        ins.inst_id = id_next;
        id_next = id_next + 64'd1;
        exp_retired = exp_retired + 32'd1;
        check_val("exit_o", 32'(exit_o), 32'd0);
        send(ins);
        idle(1);
        check_val("exit_o", 32'(exit_o), 32'd0);
        idle(1);
        check_val("exit_o", 32'(exit_o), 32'd0);
        idle(1);
        check_val("exit_o", 32'(exit_o), 32'd1); // two edges after the take.
        issue(make_ins(COPY_B, OPB_IMM, WB_ALU, 5'd4, 5'd0, 5'd0, 32'h77)); // later retirement.
        idle(5);
        check_val("exit_o", 32'(exit_o), 32'd1);
        check_val("retire_count_o", retire_count_o, exp_retired);
    endtask

// File: verif/backend_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module backend_tb import core_pkg::*; ();

    localparam int CLK_HALF      = 20;
    localparam int CLK_PERIOD    = 2 * CLK_HALF;
    localparam int RESET_CYCLES  = 4;
    localparam int TEST_CYCLES   = 220; // all directed tests need about 200 cycles.
    localparam int MARGIN_CYCLES = 100;
    localparam int MAX_STALLS    = 4;

    logic                  clk;
    logic                  rst_n_i;
    logic                  issue_valid_i;
    issue_t                issue_i;
    logic [REG_AW-1:0]     dbg_addr_i;
    logic                  stall_o;
    logic [`CORE_XLEN-1:0] dbg_data_o;
    logic [31:0]           retire_count_o;
    logic                  exit_o;

    integer      seed;
    logic [31:0] model_rf [`CORE_NREGS];
    logic [31:0] mem_word;
    logic [31:0] pc_next;
    logic [63:0] id_next;
    logic [31:0] exp_retired;
    int          last_stalls;

    backend_top uut (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .issue_valid_i  (issue_valid_i),
        .issue_i        (issue_i),
        .dbg_addr_i     (dbg_addr_i),
        .stall_o        (stall_o),
        .dbg_data_o     (dbg_data_o),
        .retire_count_o (retire_count_o),
        .exit_o         (exit_o)
    );

    always #(CLK_HALF) clk = ~clk;

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("Some tests failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // reference ALU built from the RV32 opcode rules.
    function automatic logic [31:0] alu_model(input alu_op_e op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ADD:     return a + b;
            SUB:     return a + ~b + 32'd1;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << sh;
            SRL:     return a >> sh;
            SRA:     return (a >> sh) | (a[31] ? ~(32'hffffffff >> sh) : 32'h0);
            SLT:     return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            SLTU:    return {31'd0, a < b};
            default: return b;
        endcase
    endfunction

    `include "backend_tests.svh"

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES));
        $display("watchdog expired before the tests finished");
        $display("Some tests failed");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        seed          = 32'hbcc59b0e;
        clk           = 1'b0;
        rst_n_i       = 1'b0;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        dbg_addr_i    = '0;
        mem_word      = '0;
        pc_next       = 32'h0000_1000; // well away from the exit pc.
        id_next       = 64'd1;
        exp_retired   = '0;
        last_stalls   = 0;
        for (int r = 0; r < `CORE_NREGS; r++) begin
            if (r == 0)
                model_rf[r[4:0]] = '0;
            else if (r == 2)
                model_rf[r[4:0]] = `CORE_SP_RESET;
            else
                model_rf[r[4:0]] = `CORE_REG_RESET;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        reset_values();
        alu_forwarding();
        load_extension();
        load_use_stall();
        link_and_retire();
        exit_flag();

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+verilog
+incdir+verif
verilog/core_pkg.sv
verilog/regfile.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/writeback_stage.sv
verilog/pipe_control.sv
verilog/backend_top.sv
verif/backend_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the backend testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
    -f sim.f --top-module backend_tb

./obj_dir/Vbackend_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
